// File: design/ppi_pkg.sv
package ppi_pkg;

    // Host addresses of the four locations
    typedef enum logic [1:0] {
        port_a  = 2'd0,
        port_b  = 2'd1,
        port_c  = 2'd2,
        control = 2'd3
    } ppi_addr_e;

    // Kind of control word, taken from its top bit
    typedef enum logic {
        ctl_bit_set_reset = 1'b0,
        ctl_mode_set      = 1'b1
    } ppi_ctl_op_e;

    // Group directions, a field at 1 makes the group an input
    typedef struct packed {
        logic a_in;
        logic b_in;
        logic c_hi_in;
        logic c_lo_in;
    } ppi_dir_t;

    // Write request from the bus front end, valid for one cycle
    typedef struct packed {
        logic       wr_a;
        logic       wr_b;
        logic       wr_c;
        logic       wr_ctl;
        logic [7:0] data;
    } ppi_wr_req_t;

    // Opcode bit of a control word
    localparam int ctl_op_bit = 7;

    // Mode-set word, direction bits
    // Mode select bits 6:5 and 2 are ignored, every group runs as mode 0
    localparam int ctl_a_dir_bit    = 4;
    localparam int ctl_c_hi_dir_bit = 3;
    localparam int ctl_b_dir_bit    = 1;
    localparam int ctl_c_lo_dir_bit = 0;

    // Bit-set/reset word fields
    localparam int bsr_index_msb = 3;
    localparam int bsr_index_lsb = 1;
    localparam int bsr_value_bit = 0;

    // Width of the port C bit index
    localparam int bsr_index_width = bsr_index_msb - bsr_index_lsb + 1;

endpackage

// File: design/ppi_bus_control.sv
`timescale 1ns/1ps

module ppi_bus_control (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 chip_select,
    input  logic                 read_enable,
    input  logic                 write_enable,
    input  ppi_pkg::ppi_addr_e   address,
    input  logic [7:0]           data_in,
    output ppi_pkg::ppi_wr_req_t wr_req,
    output ppi_pkg::ppi_addr_e   rd_sel,
    output logic                 rd_active,
    output logic                 ack
);
    import ppi_pkg::*;

    logic       we_q;
    logic       cs_q;
    logic       wr_edge;
    logic       wr_pulse;
    logic       start_q;
    ppi_addr_e  addr_q;
    logic [7:0] data_q;

    // A write starts on the rising edge of write_enable while selected
    assign wr_edge = write_enable & ~we_q & chip_select;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            we_q     <= 1'b0;
            cs_q     <= 1'b0;
            wr_pulse <= 1'b0;
            start_q  <= 1'b0;
            ack      <= 1'b0;
        end else begin
            we_q     <= write_enable;
            cs_q     <= chip_select;
            wr_pulse <= wr_edge;
            // Access counts once per chip_select assertion
            start_q  <= (write_enable | read_enable) & chip_select & ~cs_q;
            ack      <= start_q;
        end
    end

    // Address and data captured in the cycle of the write edge
    always_ff @(posedge clock) begin
        if (wr_edge) begin
            addr_q <= address;
            data_q <= data_in;
        end
    end

    // One strobe, chosen by the captured address
    always_comb begin
        wr_req      = '0;
        wr_req.data = data_q;
        if (wr_pulse) begin
            case (addr_q)
                port_a:  wr_req.wr_a   = 1'b1;
                port_b:  wr_req.wr_b   = 1'b1;
                port_c:  wr_req.wr_c   = 1'b1;
                default: wr_req.wr_ctl = 1'b1;
            endcase
        end
    end

    // Reads go straight to the top level multiplexer
    assign rd_sel    = address;
    assign rd_active = read_enable & chip_select;

endmodule

// File: design/ppi_mode_register.sv
`timescale 1ns/1ps

module ppi_mode_register (
    input  logic                                  clock,
    input  logic                                  reset,
    input  ppi_pkg::ppi_wr_req_t                  wr_req,
    output ppi_pkg::ppi_dir_t                     dir,
    output logic                                  clear,
    output logic                                  bsr_valid,
    output logic [ppi_pkg::bsr_index_width-1:0]   bsr_index,
    output logic                                  bsr_value
);
    import ppi_pkg::*;

    ppi_ctl_op_e op;
    logic        mode_set;
    logic        bit_set_reset;

    // Opcode of the word on the bus
    assign op = ppi_ctl_op_e'(wr_req.data[ctl_op_bit]);

    always_comb begin
        mode_set      = 1'b0;
        bit_set_reset = 1'b0;
        if (wr_req.wr_ctl) begin
            case (op)
                ctl_mode_set:      mode_set      = 1'b1;
                ctl_bit_set_reset: bit_set_reset = 1'b1;
            endcase
        end
    end

    // Direction word resets to all inputs
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dir <= '{default: 1'b1};
        end else if (mode_set) begin
            dir <= '{
                a_in:    wr_req.data[ctl_a_dir_bit],
                b_in:    wr_req.data[ctl_b_dir_bit],
                c_hi_in: wr_req.data[ctl_c_hi_dir_bit],
                c_lo_in: wr_req.data[ctl_c_lo_dir_bit]
            };
        end
    end

    // Clear lands on the same edge as the new direction
    assign clear = mode_set;

    // Single bit update for port C
    assign bsr_valid = bit_set_reset;
    assign bsr_index = wr_req.data[bsr_index_msb:bsr_index_lsb];
    assign bsr_value = wr_req.data[bsr_value_bit];

endmodule

// File: design/ppi_port.sv
`timescale 1ns/1ps

module ppi_port #(
    parameter int input_sync_stages = 2
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       wr_strobe,
    input  logic [7:0] wr_data,
    input  logic       clear,
    input  logic       is_input,
    input  logic [7:0] pins_in,
    output logic [7:0] pins_out,
    output logic [7:0] pins_oe,
    output logic [7:0] read_data
);

    logic [7:0] out_latch;
    logic [7:0] sync_q [input_sync_stages];

    // Output latch, cleared by every mode-set word
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_latch <= 8'h00;
        end else if (clear) begin
            out_latch <= 8'h00;
        end else if (wr_strobe) begin
            out_latch <= wr_data;
        end
    end

    // Pin synchronizer
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < input_sync_stages; i++) begin
                sync_q[i] <= 8'h00;
            end
        end else begin
            sync_q[0] <= pins_in;
            for (int i = 1; i < input_sync_stages; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign pins_out = out_latch;
    assign pins_oe  = {8{~is_input}};

    // Inputs read the pins, outputs read back the latch
    assign read_data = is_input ? sync_q[input_sync_stages-1] : out_latch;

endmodule

// File: design/ppi_port_c.sv
`timescale 1ns/1ps

module ppi_port_c #(
    parameter int input_sync_stages = 2
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                wr_strobe,
    input  logic [7:0]                          wr_data,
    input  logic                                clear,
    input  logic                                bsr_valid,
    input  logic [ppi_pkg::bsr_index_width-1:0] bsr_index,
    input  logic                                bsr_value,
    input  logic                                hi_is_input,
    input  logic                                lo_is_input,
    input  logic [7:0]                          pins_in,
    output logic [7:0]                          pins_out,
    output logic [7:0]                          pins_oe,
    output logic [7:0]                          read_data
);

    logic [7:0] out_latch;
    logic [7:0] in_mask;
    logic [7:0] sync_q [input_sync_stages];

    // Whole byte write, single bit update, or clear
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_latch <= 8'h00;
        end else if (clear) begin
            out_latch <= 8'h00;
        end else if (wr_strobe) begin
            out_latch <= wr_data;
        end else if (bsr_valid) begin
            out_latch[bsr_index] <= bsr_value;
        end
    end

    // Pin synchronizer
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < input_sync_stages; i++) begin
                sync_q[i] <= 8'h00;
            end
        end else begin
            sync_q[0] <= pins_in;
            for (int i = 1; i < input_sync_stages; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Each nibble has its own direction
    assign in_mask = {{4{hi_is_input}}, {4{lo_is_input}}};

    assign pins_out = out_latch;
    assign pins_oe  = ~in_mask;

    // Input bits from the pins, output bits from the latch
    assign read_data = (sync_q[input_sync_stages-1] & in_mask) | (out_latch & ~in_mask);

endmodule

// File: design/ppi_top.sv
`timescale 1ns/1ps

module ppi_top #(
    parameter int input_sync_stages = 2
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               chip_select,
    input  logic               read_enable,
    input  logic               write_enable,
    input  ppi_pkg::ppi_addr_e address,
    input  logic [7:0]         data_in,
    output logic [7:0]         data_out,
    output logic               ack,
    input  logic [7:0]         port_a_in,
    output logic [7:0]         port_a_out,
    output logic [7:0]         port_a_oe,
    input  logic [7:0]         port_b_in,
    output logic [7:0]         port_b_out,
    output logic [7:0]         port_b_oe,
    input  logic [7:0]         port_c_in,
    output logic [7:0]         port_c_out,
    output logic [7:0]         port_c_oe
);
    import ppi_pkg::*;

    ppi_wr_req_t                wr_req;
    ppi_addr_e                  rd_sel;
    logic                       rd_active;
    ppi_dir_t                   dir;
    logic                       clear;
    logic                       bsr_valid;
    logic [bsr_index_width-1:0] bsr_index;
    logic                       bsr_value;
    logic [7:0]                 a_rd_data;
    logic [7:0]                 b_rd_data;
    logic [7:0]                 c_rd_data;

    ppi_bus_control u_bus_control (
        .clock, .reset, .chip_select, .read_enable, .write_enable,
        .address, .data_in, .wr_req, .rd_sel, .rd_active, .ack
    );

    ppi_mode_register u_mode_register (
        .clock, .reset, .wr_req, .dir, .clear, .bsr_valid, .bsr_index, .bsr_value
    );

    ppi_port #(.input_sync_stages(input_sync_stages)) u_port_a (
        .clock, .reset, .wr_strobe(wr_req.wr_a), .wr_data(wr_req.data), .clear,
        .is_input(dir.a_in), .pins_in(port_a_in), .pins_out(port_a_out),
        .pins_oe(port_a_oe), .read_data(a_rd_data)
    );

    ppi_port #(.input_sync_stages(input_sync_stages)) u_port_b (
        .clock, .reset, .wr_strobe(wr_req.wr_b), .wr_data(wr_req.data), .clear,
        .is_input(dir.b_in), .pins_in(port_b_in), .pins_out(port_b_out),
        .pins_oe(port_b_oe), .read_data(b_rd_data)
    );

    ppi_port_c #(.input_sync_stages(input_sync_stages)) u_port_c (
        .clock, .reset, .wr_strobe(wr_req.wr_c), .wr_data(wr_req.data), .clear,
        .bsr_valid, .bsr_index, .bsr_value, .hi_is_input(dir.c_hi_in),
        .lo_is_input(dir.c_lo_in), .pins_in(port_c_in), .pins_out(port_c_out),
        .pins_oe(port_c_oe), .read_data(c_rd_data)
    );

    // Read multiplexer, the control address reads back port A
    always_comb begin
        data_out = 8'h00;
        if (rd_active) begin
            case (rd_sel)
                port_a:  data_out = a_rd_data;
                port_b:  data_out = b_rd_data;
                port_c:  data_out = c_rd_data;
                default: data_out = a_rd_data;
            endcase
        end
    end

endmodule

// File: bench/ppi_chk.sv
`timescale 1ns/1ps

module ppi_chk (
    input logic                 clock,
    input logic                 reset,
    input logic                 chip_select,
    input ppi_pkg::ppi_wr_req_t wr_req,
    input logic                 ack
);

    logic [3:0] strobes;

    assign strobes = {wr_req.wr_a, wr_req.wr_b, wr_req.wr_c, wr_req.wr_ctl};

    // A write reaches one target only
    a_one_strobe: assert property (
        @(posedge clock) disable iff (reset) $onehot0(strobes)
    ) else $error("more than one write strobe high in the same cycle");

    // Acknowledge is a single cycle pulse
    a_ack_pulse: assert property (
        @(posedge clock) disable iff (reset) ack |=> !ack
    ) else $error("ack stayed high for more than one cycle");

    // Strobes and ack only follow a selected access
    a_cs_before: assert property (
        @(posedge clock) disable iff (reset)
        (|strobes || ack) |-> (chip_select || $past(chip_select) || $past(chip_select, 2))
    ) else $error("strobe or ack without chip_select in the two cycles before");

endmodule

bind ppi_bus_control ppi_chk u_chk (
    .clock,
    .reset,
    .chip_select,
    .wr_req,
    .ack
);

// File: bench/ppi_tb.sv
`timescale 1ns/1ps

module ppi_tb;
    import ppi_pkg::*;

    localparam int ack_timeout = 8;
    localparam int mode_rounds = 8;
    localparam int bsr_rounds  = 16;

    logic       clock;
    logic       reset;
    logic       chip_select;
    logic       read_enable;
    logic       write_enable;
    ppi_addr_e  address;
    logic [7:0] data_in;
    logic [7:0] data_out;
    logic       ack;
    logic [7:0] port_a_in;
    logic [7:0] port_a_out;
    logic [7:0] port_a_oe;
    logic [7:0] port_b_in;
    logic [7:0] port_b_out;
    logic [7:0] port_b_oe;
    logic [7:0] port_c_in;
    logic [7:0] port_c_out;
    logic [7:0] port_c_oe;

    // Model of the direction word and the three latches
    ppi_dir_t   model_dir;
    logic [7:0] model_a;
    logic [7:0] model_b;
    logic [7:0] model_c;
    string      current_test;
    int         access_count;
    int         ack_count = 0;
    event       access_done;

    ppi_top dut (.*);

    always #4 clock = ~clock;

    always @(posedge clock) begin
        if (!reset && ack) begin
            ack_count++;
        end
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch %s: expected %02h actual %02h",
                                        name, expected, actual));
        end
    endtask

    task automatic check_dir(input string name, input ppi_dir_t expected,
                             input ppi_dir_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch %s: expected %04b actual %04b",
                                        name, expected, actual));
        end
    endtask

    task automatic check_ack(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch %s: expected %0b actual %0b",
                                        name, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // Expected read data from the model and the pins
    function automatic logic [7:0] expected_read(input ppi_addr_e addr);
        logic [7:0] result;
        logic       group_in;
        result = 8'h00;
        case (addr)
            port_b: result = model_dir.b_in ? port_b_in : model_b;
            port_c: begin
                for (int i = 0; i < 8; i++) begin
                    group_in  = (i >= 4) ? model_dir.c_hi_in : model_dir.c_lo_in;
                    result[i] = group_in ? port_c_in[i] : model_c[i];
                end
            end
            default: result = model_dir.a_in ? port_a_in : model_a;
        endcase
        return result;
    endfunction

    // Pins actually driven, latch bits of output groups only
    function automatic logic [7:0] expected_drive(input ppi_addr_e addr);
        case (addr)
            port_b:  return model_dir.b_in ? 8'h00 : model_b;
            port_c:  return {model_dir.c_hi_in ? 4'h0 : model_c[7:4],
                             model_dir.c_lo_in ? 4'h0 : model_c[3:0]};
            default: return model_dir.a_in ? 8'h00 : model_a;
        endcase
    endfunction

    function automatic logic input_from_oe(input logic [7:0] oe, input logic [7:0] mask);
        if ((oe & mask) == 8'h00) begin
            return 1'b1;
        end
        if ((oe & mask) == mask) begin
            return 1'b0;
        end
        return 1'bx;
    endfunction

    function automatic ppi_dir_t observed_dir();
        ppi_dir_t d;
        d.a_in    = input_from_oe(port_a_oe, 8'hFF);
        d.b_in    = input_from_oe(port_b_oe, 8'hFF);
        d.c_hi_in = input_from_oe(port_c_oe, 8'hF0);
        d.c_lo_in = input_from_oe(port_c_oe, 8'h0F);
        return d;
    endfunction

    // Same control word rules as the device
    task automatic apply_write(input ppi_addr_e addr, input logic [7:0] data);
        case (addr)
            port_a: model_a = data;
            port_b: model_b = data;
            port_c: model_c = data;
            default: begin
                if (data[7]) begin
                    model_dir.a_in    = data[4];
                    model_dir.c_hi_in = data[3];
                    model_dir.b_in    = data[1];
                    model_dir.c_lo_in = data[0];
                    model_a = 8'h00;
                    model_b = 8'h00;
                    model_c = 8'h00;
                end else begin
                    model_c[data[3:1]] = data[0];
                end
            end
        endcase
    endtask

    task automatic wait_for_ack(input string what);
        int waited;
        waited = 0;
        while (ack !== 1'b1) begin
            if (waited == ack_timeout) begin
                stop_with_failure($sformatf("no ack within %0d cycles on %s",
                                            ack_timeout, what));
            end else begin
                next_cycle();
                waited++;
            end
        end
    endtask

    task automatic finish_access();
        access_count++;
        -> access_done;
        next_cycle();
        check_ack({current_test, " ack width"}, 1'b0, ack);
        repeat (2) next_cycle();
    endtask

    task automatic bus_write(input ppi_addr_e addr, input logic [7:0] data);
        chip_select  = 1'b1;
        write_enable = 1'b1;
        address      = addr;
        data_in      = data;
        wait_for_ack($sformatf("write to %s", addr.name()));
        chip_select  = 1'b0;
        write_enable = 1'b0;
        apply_write(addr, data);
        finish_access();
    endtask

    task automatic bus_read(input ppi_addr_e addr, output logic [7:0] data);
        chip_select = 1'b1;
        read_enable = 1'b1;
        address     = addr;
        wait_for_ack($sformatf("read of %s", addr.name()));
        data        = data_out;
        chip_select = 1'b0;
        read_enable = 1'b0;
        finish_access();
    endtask

    task automatic read_and_check(input ppi_addr_e addr);
        logic [7:0] value;
        bus_read(addr, value);
        check_byte({current_test, " read ", addr.name()}, expected_read(addr), value);
    endtask

    task automatic read_all_ports();
        read_and_check(port_a);
        read_and_check(port_b);
        read_and_check(port_c);
        read_and_check(control);
    endtask

    // New pin values, held past the synchronizer delay
    task automatic randomize_pins();
        port_a_in = 8'($urandom);
        port_b_in = 8'($urandom);
        port_c_in = 8'($urandom);
        repeat (3) next_cycle();
    endtask

    // Driven pins and enables follow the model after every access
    always begin
        @(access_done);
        check_dir({current_test, " direction"}, model_dir, observed_dir());
        check_byte({current_test, " pins a"}, expected_drive(port_a), port_a_out & port_a_oe);
        check_byte({current_test, " pins b"}, expected_drive(port_b), port_b_out & port_b_oe);
        check_byte({current_test, " pins c"}, expected_drive(port_c), port_c_out & port_c_oe);
    end

    initial begin
        logic [7:0] bsr_word;
        clock        = 1'b0;
        reset        = 1'b1;
        chip_select  = 1'b0;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        address      = port_a;
        data_in      = 8'h00;
        port_a_in    = 8'h00;
        port_b_in    = 8'h00;
        port_c_in    = 8'h00;
        model_dir    = '1;
        model_a      = 8'h00;
        model_b      = 8'h00;
        model_c      = 8'h00;
        access_count = 0;
        current_test = "reset state";
        void'($urandom(32'h2600_11bd));
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        // All groups are inputs out of reset
        check_dir({current_test, " direction"}, model_dir, observed_dir());
        randomize_pins();
        read_all_ports();

        for (int round = 0; round < mode_rounds; round++) begin
            current_test = $sformatf("mode round %0d", round);
            bus_write(control, {1'b1, 7'($urandom)});
            check_byte({current_test, " latch a"}, 8'h00, port_a_out);
            check_byte({current_test, " latch b"}, 8'h00, port_b_out);
            check_byte({current_test, " latch c"}, 8'h00, port_c_out);
            read_all_ports();
            bus_write(port_a, 8'($urandom));
            bus_write(port_b, 8'($urandom));
            bus_write(port_c, 8'($urandom));
            read_all_ports();
            randomize_pins();
            read_all_ports();
        end

        // Port C upper output and lower input, then the reverse
        for (int setup = 0; setup < 2; setup++) begin
            current_test = $sformatf("bsr setup %0d", setup);
            bus_write(control, (setup == 0) ? 8'h81 : 8'h88);
            for (int n = 0; n < bsr_rounds; n++) begin
                bsr_word = {4'b0000, 3'($urandom), 1'($urandom)};
                bus_write(control, bsr_word);
                check_byte({current_test, " latch c"}, model_c, port_c_out);
                randomize_pins();
                read_and_check(port_c);
            end
        end

        current_test = "ack count";
        if (ack_count != access_count) begin
            stop_with_failure($sformatf("mismatch %s: expected %0d actual %0d",
                                        current_test, access_count, ack_count));
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// File: vlog.f
design/ppi_pkg.sv
design/ppi_bus_control.sv
design/ppi_mode_register.sv
design/ppi_port.sv
design/ppi_port_c.sv
design/ppi_top.sv
bench/ppi_chk.sv
bench/ppi_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= ppi_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
